// ==== compile.f ====
+incdir+.
isa_pkg.sv
window_pkg.sv
dispatch_ctrl.sv
reservation_station.sv
reorder_buffer.sv
ooo_window_top.sv
tb_window_checker.sv
tb_ooo_window.sv

// ==== dispatch_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module dispatch_ctrl
    import window_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic dispatch_req,
    input  logic rs_full,
    input  logic rob_full,
    output logic dispatch_ack,
    output logic alloc
);

    dispatch_state_e state;
    dispatch_state_e state_nxt;
    logic            room;

    // Both queues must take the entry
    assign room = !rs_full && !rob_full;

    // ==============================
    // Handshake FSM
    // ==============================

    always_comb begin
        state_nxt = state;
        case (state)
            disp_idle: begin
                if (dispatch_req && room) begin
                    state_nxt = disp_grant;
                end
            end
            disp_grant: begin
                if (!dispatch_req) begin  // Requester saw ack
                    state_nxt = disp_release;
                end
            end
            disp_release: begin
                state_nxt = disp_idle;  // Ack already low here
            end
            default: begin
                state_nxt = disp_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= disp_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Queues write on the same edge that raises ack, payload still held
    assign alloc        = (state == disp_idle) && dispatch_req && room;
    assign dispatch_ack = (state == disp_grant);

    // ==============================
    // Checks
    // ==============================

    // Ack answers a request seen on the edge before
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(dispatch_ack) |-> $past(dispatch_req)
    ) else $error("dispatch_ack rose without dispatch_req");

endmodule : dispatch_ctrl

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

`include "ooo_consts.svh"

package isa_pkg;

    // ==============================
    // Word and register types
    // ==============================

    typedef logic [`XLEN_W-1:0]     word_t;      // One data word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // Destination register

    // ==============================
    // Operation classes
    // ==============================

    // Selects the execution unit downstream
    typedef enum logic [2:0] {
        int_alu = 3'd0,
        int_mul = 3'd1,
        int_div = 3'd2,
        fp_alu  = 3'd3,
        system  = 3'd4  // CSR and trap style ops
    } op_class_e;

endpackage : isa_pkg

`default_nettype wire

// ==== ooo_consts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// ==============================
// Datapath widths
// ==============================

`define XLEN_W      32  // Data word
`define REG_ADDR_W  5   // Architectural register number

// ==============================
// Window depths
// ==============================

`define ROB_DEPTH   8   // Reorder buffer entries
`define ROB_TAG_W   3   // Must cover ROB_DEPTH entries
`define RS_DEPTH    4   // Reservation station slots

`endif

// ==== ooo_window_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module ooo_window_top
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dispatch_req,
    input  dispatch_t  dispatch_in,
    output logic       dispatch_ack,
    input  logic       issue_en,
    output issue_t     issue_out,
    output logic       issue_valid,
    input  logic       wb_valid,
    input  writeback_t wb,
    input  logic       commit_en,
    output commit_t    commit_out,
    output logic       commit_valid
);

    logic     rs_full;
    logic     rob_full;
    logic     alloc;      // One pulse per accepted instruction
    rob_tag_t alloc_tag;  // ROB tail handed to the new RS entry

    // ==============================
    // Dispatch
    // ==============================

    dispatch_ctrl i_dispatch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_req (dispatch_req),
        .rs_full      (rs_full),
        .rob_full     (rob_full),
        .dispatch_ack (dispatch_ack),
        .alloc        (alloc)
    );

    // ==============================
    // Queues
    // ==============================

    reservation_station i_reservation_station (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .dispatch_in (dispatch_in),
        .alloc_tag   (alloc_tag),
        .wb          (wb),
        .wb_valid    (wb_valid),
        .issue_en    (issue_en),
        .full        (rs_full),
        .issue_out   (issue_out),
        .issue_valid (issue_valid)
    );

    reorder_buffer i_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_rd     (dispatch_in.rd),
        .wb           (wb),
        .wb_valid     (wb_valid),
        .commit_en    (commit_en),
        .alloc_tag    (alloc_tag),
        .full         (rob_full),
        .commit_out   (commit_out),
        .commit_valid (commit_valid)
    );

endmodule : ooo_window_top

`default_nettype wire

// ==== reorder_buffer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ooo_consts.svh"

module reorder_buffer
    import isa_pkg::*;
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc,
    input  reg_addr_t  alloc_rd,
    input  writeback_t wb,
    input  logic       wb_valid,
    input  logic       commit_en,
    output rob_tag_t   alloc_tag,
    output logic       full,
    output commit_t    commit_out,
    output logic       commit_valid
);

    // ==============================
    // Entry storage
    // ==============================

    logic [`ROB_DEPTH-1:0] valid_q;  // Allocated and not yet retired
    logic [`ROB_DEPTH-1:0] done_q;   // Result written back
    reg_addr_t             rd_q     [`ROB_DEPTH];
    word_t                 result_q [`ROB_DEPTH];
    logic                  exc_q    [`ROB_DEPTH];

    rob_tag_t              head;
    rob_tag_t              tail;
    logic [`ROB_TAG_W:0]   count;    // One extra bit to reach ROB_DEPTH
    logic                  commit_fire;

    // Wraps at ROB_DEPTH even if it is not a power of two
    function automatic rob_tag_t ptr_inc(input rob_tag_t p);
        if (p == rob_tag_t'(`ROB_DEPTH - 1)) begin
            ptr_inc = '0;
        end else begin
            ptr_inc = p + 1'b1;
        end
    endfunction

    // ==============================
    // Status and commit
    // ==============================

    assign alloc_tag   = tail;
    assign full        = (count == `ROB_DEPTH);
    assign commit_fire = valid_q[head] && done_q[head] && commit_en;  // Head only

    assign commit_valid = commit_fire;
    assign commit_out   = '{tag:       head,
                            rd:        rd_q[head],
                            result:    result_q[head],
                            exception: exc_q[head]};

    // ==============================
    // Pointer and flag update
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (commit_fire) begin
                valid_q[head] <= 1'b0;
                head          <= ptr_inc(head);
            end
            if (wb_valid) begin
                done_q[wb.tag] <= 1'b1;  // Tag picks the entry directly
            end
            if (alloc) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
                tail          <= ptr_inc(tail);
            end
            case ({alloc, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Payload, written on alloc and writeback
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (wb_valid) begin
            result_q[wb.tag] <= wb.result;
            exc_q[wb.tag]    <= wb.exception;
        end
    end

    // ==============================
    // Checks
    // ==============================

    rob_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> !full
    ) else $error("reorder buffer alloc while full");

    // Execution units only return tags still in flight and unfinished
    rob_wb_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> valid_q[wb.tag] && !done_q[wb.tag]
    ) else $error("writeback to tag %0d which is not in flight", wb.tag);

endmodule : reorder_buffer

`default_nettype wire

// ==== reservation_station.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ooo_consts.svh"

module reservation_station
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc,
    input  dispatch_t  dispatch_in,
    input  rob_tag_t   alloc_tag,
    input  writeback_t wb,
    input  logic       wb_valid,
    input  logic       issue_en,
    output logic       full,
    output issue_t     issue_out,
    output logic       issue_valid
);

    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_slot_t;

    // ==============================
    // Slot storage
    // ==============================

    logic [`RS_DEPTH-1:0] slot_valid;
    src_t                 slot_src1 [`RS_DEPTH];
    src_t                 slot_src2 [`RS_DEPTH];
    issue_t               slot_info [`RS_DEPTH];  // Everything that leaves on issue

    logic [`RS_DEPTH-1:0] slot_ready;
    rs_slot_t             free_slot;
    rs_slot_t             issue_slot;
    logic                 any_ready;

    // Clears pending when the producer's tag is on the writeback bus
    function automatic src_t wake(
        input src_t     s,
        input logic     hit_valid,
        input rob_tag_t hit_tag
    );
        wake = s;
        if (hit_valid && s.pending && (s.tag == hit_tag)) begin
            wake.pending = 1'b0;
        end
    endfunction

    // ==============================
    // Slot selection
    // ==============================

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            slot_ready[i] = slot_valid[i] && !slot_src1[i].pending && !slot_src2[i].pending;
        end
    end

    // Scan downward so the lowest index wins
    always_comb begin
        free_slot  = '0;
        issue_slot = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_slot = rs_slot_t'(i);
            end
            if (slot_ready[i]) begin
                issue_slot = rs_slot_t'(i);
            end
        end
    end

    assign any_ready   = |slot_ready;
    assign full        = &slot_valid;
    assign issue_valid = any_ready && issue_en;
    assign issue_out   = slot_info[issue_slot];

    // ==============================
    // Slot update
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            if (issue_valid) begin
                slot_valid[issue_slot] <= 1'b0;  // Transfer on this edge
            end
            if (alloc) begin
                slot_valid[free_slot] <= 1'b1;  // Never the issuing slot
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (alloc && (free_slot == rs_slot_t'(i))) begin
                // Same-cycle writeback also wakes the new entry
                slot_src1[i] <= wake(dispatch_in.src1, wb_valid, wb.tag);
                slot_src2[i] <= wake(dispatch_in.src2, wb_valid, wb.tag);
                slot_info[i] <= '{tag: alloc_tag,
                                  op:  dispatch_in.op,
                                  rd:  dispatch_in.rd,
                                  imm: dispatch_in.imm};
            end else begin
                slot_src1[i] <= wake(slot_src1[i], wb_valid, wb.tag);
                slot_src2[i] <= wake(slot_src2[i], wb_valid, wb.tag);
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Dispatch must respect our full flag
    rs_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> !full
    ) else $error("reservation station alloc while full");

    rs_issue_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> !slot_src1[issue_slot].pending && !slot_src2[issue_slot].pending
    ) else $error("reservation station issued an entry with a pending source");

endmodule : reservation_station

`default_nettype wire

// ==== tb_ooo_window.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ooo_consts.svh"

module tb_ooo_window
    import isa_pkg::*;
    import window_pkg::*;
();

    localparam int NROWS    = 16;
    localparam int WAIT_MAX = 200;  // Cycles per handshake phase

    typedef struct packed {
        op_class_e  op;
        reg_addr_t  rd;
        word_t      imm;
        logic       p1;     // Source 1 pending on an older row
        logic [3:0] r1;     // Distance back to that row
        logic       p2;
        logic [3:0] r2;
        logic       exc;
        logic [3:0] delay;  // Execution latency in cycles
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       dispatch_req;
    dispatch_t  dispatch_in;
    logic       dispatch_ack;
    logic       issue_en;
    issue_t     issue_out;
    logic       issue_valid;
    logic       wb_valid;
    writeback_t wb;
    logic       commit_en;
    commit_t    commit_out;
    logic       commit_valid;

    row_t                      rows [NROWS];
    rob_tag_t  [NROWS-1:0]     exp_tag;
    reg_addr_t [NROWS-1:0]     exp_rd;
    logic      [NROWS-1:0][2:0] exp_op;
    word_t     [NROWS-1:0]     exp_imm;
    logic      [NROWS-1:0][7:0] prod1;
    logic      [NROWS-1:0][7:0] prod2;
    logic                      wb_sent [NROWS];
    int                        tag_row [`ROB_DEPTH];
    int                        q_row [$];  // Issued rows waiting in the execution units
    int                        q_due [$];
    int                        cyc = 0;
    int                        rows_sent;
    int                        hold_cnt;
    int                        tb_errors;
    logic                      aborted;
    int                        chk_errors;
    int                        commits;
    int                        stall_cycles;

    always #20 clk = ~clk;

    ooo_window_top i_ooo_window_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_req (dispatch_req),
        .dispatch_in  (dispatch_in),
        .dispatch_ack (dispatch_ack),
        .issue_en     (issue_en),
        .issue_out    (issue_out),
        .issue_valid  (issue_valid),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .commit_en    (commit_en),
        .commit_out   (commit_out),
        .commit_valid (commit_valid)
    );

    tb_window_checker #(.NROWS(NROWS)) i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_req (dispatch_req),
        .dispatch_ack (dispatch_ack),
        .issue_valid  (issue_valid),
        .issue_out    (issue_out),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit_out   (commit_out),
        .exp_tag      (exp_tag),
        .exp_rd       (exp_rd),
        .exp_op       (exp_op),
        .exp_imm      (exp_imm),
        .prod1        (prod1),
        .prod2        (prod2),
        .errors       (chk_errors),
        .commits      (commits),
        .stall_cycles (stall_cycles)
    );

    // Execution unit result, a fixed mix of immediate and tag
    function automatic word_t unit_result(input word_t imm, input rob_tag_t tag);
        return (imm << 4) ^ {28'h0, 1'b1, tag};
    endfunction

    // A waiting request names this tag, so its writeback would be missed
    function automatic logic held_by_dispatch(input rob_tag_t tag);
        return dispatch_req && !dispatch_ack &&
               ((dispatch_in.src1.pending && dispatch_in.src1.tag == tag) ||
                (dispatch_in.src2.pending && dispatch_in.src2.tag == tag));
    endfunction

    // ==============================
    // Stimulus table
    // ==============================

    task automatic load_table();
        rows[0]  = '{int_alu, 5'd1,  32'h100, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd4};
        rows[1]  = '{int_mul, 5'd2,  32'h101, 1'b1, 4'd1, 1'b0, 4'd0, 1'b0, 4'd1};
        rows[2]  = '{int_alu, 5'd3,  32'h102, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd6};
        rows[3]  = '{int_div, 5'd4,  32'h103, 1'b1, 4'd1, 1'b1, 4'd2, 1'b1, 4'd2};
        rows[4]  = '{fp_alu,  5'd5,  32'h104, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd5};
        rows[5]  = '{int_alu, 5'd6,  32'h105, 1'b1, 4'd1, 1'b0, 4'd0, 1'b0, 4'd1};
        rows[6]  = '{system,  5'd7,  32'h106, 1'b0, 4'd0, 1'b0, 4'd0, 1'b1, 4'd3};
        rows[7]  = '{int_alu, 5'd8,  32'h107, 1'b0, 4'd0, 1'b1, 4'd2, 1'b0, 4'd7};
        rows[8]  = '{int_mul, 5'd9,  32'h108, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd2};
        rows[9]  = '{int_alu, 5'd10, 32'h109, 1'b1, 4'd1, 1'b1, 4'd3, 1'b0, 4'd1};
        rows[10] = '{int_div, 5'd11, 32'h10a, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd5};
        rows[11] = '{fp_alu,  5'd12, 32'h10b, 1'b1, 4'd1, 1'b0, 4'd0, 1'b0, 4'd2};
        rows[12] = '{int_alu, 5'd13, 32'h10c, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd1};
        rows[13] = '{int_mul, 5'd14, 32'h10d, 1'b1, 4'd2, 1'b1, 4'd1, 1'b0, 4'd4};
        rows[14] = '{system,  5'd15, 32'h10e, 1'b0, 4'd0, 1'b0, 4'd0, 1'b1, 4'd3};
        rows[15] = '{int_alu, 5'd16, 32'h10f, 1'b1, 4'd1, 1'b1, 4'd3, 1'b0, 4'd2};
        for (int k = 0; k < NROWS; k++) begin
            exp_tag[k] = rob_tag_t'(k % `ROB_DEPTH);  // Tags run in dispatch order
            exp_rd[k]  = rows[k].rd;
            exp_op[k]  = rows[k].op;
            exp_imm[k] = rows[k].imm;
            prod1[k]   = rows[k].p1 ? 8'(k - rows[k].r1) : 8'hff;
            prod2[k]   = rows[k].p2 ? 8'(k - rows[k].r2) : 8'hff;
            wb_sent[k] = 1'b0;
        end
    endtask

    // Four-phase dispatch of one row, pending only while the producer is unfinished
    task automatic send_row(input int k);
        dispatch_t d;
        int        n;
        @(negedge clk);
        d.op           = rows[k].op;
        d.rd           = rows[k].rd;
        d.imm          = rows[k].imm;
        d.src1.pending = rows[k].p1 && !wb_sent[k - rows[k].r1];
        d.src1.tag     = rob_tag_t'((k - rows[k].r1) % `ROB_DEPTH);
        d.src2.pending = rows[k].p2 && !wb_sent[k - rows[k].r2];
        d.src2.tag     = rob_tag_t'((k - rows[k].r2) % `ROB_DEPTH);
        dispatch_in  = d;
        dispatch_req = 1'b1;
        for (n = 0; n < WAIT_MAX && !dispatch_ack; n++) @(negedge clk);
        if (!dispatch_ack) begin
            tb_errors++;
            aborted = 1'b1;
            $display("Row %0d was never acknowledged within %0d cycles", k, WAIT_MAX);
            return;
        end
        tag_row[k % `ROB_DEPTH] = k;
        rows_sent    = k + 1;
        dispatch_req = 1'b0;
        for (n = 0; n < WAIT_MAX && dispatch_ack; n++) @(negedge clk);
        if (dispatch_ack) begin
            tb_errors++;
            aborted = 1'b1;
            $display("Acknowledge of row %0d never fell after the request dropped", k);
        end
    endtask

    // ==============================
    // Execution unit model
    // ==============================

    always @(posedge clk) begin
        int r;
        if (rst_n) begin
            cyc++;
            if (issue_valid) begin
                r = tag_row[issue_out.tag];
                q_row.push_back(r);
                q_due.push_back(cyc + rows[r].delay);
            end
        end
    end

    always @(negedge clk) begin
        int pick;
        int r;
        pick = -1;
        if (rst_n) begin
            for (int i = 0; i < q_row.size(); i++) begin
                if (pick < 0 && q_due[i] <= cyc &&
                    !held_by_dispatch(rob_tag_t'(q_row[i] % `ROB_DEPTH))) begin
                    pick = i;  // Oldest due result goes first
                end
            end
            wb_valid = (pick >= 0);
            if (pick >= 0) begin
                r            = q_row[pick];
                wb.tag       = rob_tag_t'(r % `ROB_DEPTH);
                wb.result    = unit_result(rows[r].imm, wb.tag);
                wb.exception = rows[r].exc;
                wb_sent[r]   = 1'b1;
                q_row.delete(pick);
                q_due.delete(pick);
            end
            issue_en = (rows_sent >= 10) ? (($urandom % 3) != 0) : 1'b1;
            if (rows_sent >= 4 && hold_cnt < 60) begin
                hold_cnt++;  // ROB fills while commit is held
            end
            commit_en = !(rows_sent >= 4 && hold_cnt < 60);
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int n;
        void'($urandom(32'h8706));
        rst_n        = 1'b0;
        dispatch_req = 1'b0;
        dispatch_in  = '0;
        issue_en     = 1'b0;
        wb_valid     = 1'b0;
        wb           = '0;
        commit_en    = 1'b0;
        aborted      = 1'b0;
        tb_errors    = 0;
        rows_sent    = 0;
        hold_cnt     = 0;
        for (int t = 0; t < `ROB_DEPTH; t++) begin
            tag_row[t] = 0;
        end
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < NROWS && !aborted; k++) begin
            send_row(k);
        end
        for (n = 0; n < 1000 && !aborted && commits < NROWS; n++) @(negedge clk);
        if (!aborted && commits < NROWS) begin
            tb_errors++;
            $display("Only %0d of %0d rows committed before the drain timeout", commits, NROWS);
        end
        if (stall_cycles == 0) begin
            tb_errors++;
            $display("Dispatch never stalled on a full reorder buffer");
        end
        $display("Error count: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_ooo_window

`default_nettype wire

// ==== tb_window_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ooo_consts.svh"

module tb_window_checker
    import isa_pkg::*;
    import window_pkg::*;
#(
    parameter int NROWS = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dispatch_req,
    input  logic                        dispatch_ack,
    input  logic                        issue_valid,
    input  issue_t                      issue_out,
    input  logic                        wb_valid,
    input  writeback_t                  wb,
    input  logic                        commit_valid,
    input  commit_t                     commit_out,
    input  rob_tag_t  [NROWS-1:0]       exp_tag,
    input  reg_addr_t [NROWS-1:0]       exp_rd,
    input  logic      [NROWS-1:0][2:0]  exp_op,
    input  word_t     [NROWS-1:0]       exp_imm,
    input  logic      [NROWS-1:0][7:0]  prod1,   // Producer row, 8'hff when none
    input  logic      [NROWS-1:0][7:0]  prod2,
    output int                          errors,
    output int                          commits,
    output int                          stall_cycles
);

    int    err_cnt = 0;
    int    n_disp = 0;
    int    n_commit = 0;
    int    stall_cnt = 0;
    logic  ack_q = 1'b0;
    int    row_of_tag [`ROB_DEPTH];  // Latest row holding each tag
    logic  done [NROWS];
    word_t wb_result [`ROB_DEPTH];
    logic  wb_exc [`ROB_DEPTH];

    assign errors       = err_cnt;
    assign commits      = n_commit;
    assign stall_cycles = stall_cnt;

    initial begin
        for (int i = 0; i < NROWS; i++) begin
            done[i] = 1'b0;
        end
        for (int t = 0; t < `ROB_DEPTH; t++) begin
            row_of_tag[t] = 0;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        err_cnt++;
        $display("ERROR at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, exp_v, act_v);
    endtask

    task automatic check_producer(input int row, input logic [7:0] prod);
        if (prod != 8'hff && !done[prod]) begin
            err_cnt++;
            $display("Row %0d issued at %0t ns before producer row %0d was written back",
                     row, $time, prod);
        end
    endtask

    // Commits must follow dispatch order and carry their own writeback
    task automatic check_commit();
        rob_tag_t t;
        if (n_commit >= NROWS) begin
            err_cnt++;
            $display("Extra commit of tag %0d at %0t ns", commit_out.tag, $time);
            return;
        end
        t = exp_tag[n_commit];
        if (commit_out.tag !== t) report_mismatch("commit_out.tag", t, commit_out.tag);
        if (commit_out.rd !== exp_rd[n_commit]) begin
            report_mismatch("commit_out.rd", exp_rd[n_commit], commit_out.rd);
        end
        if (!done[n_commit]) begin
            err_cnt++;
            $display("Row %0d committed at %0t ns without a writeback", n_commit, $time);
        end
        if (commit_out.result !== wb_result[t]) begin
            report_mismatch("commit_out.result", wb_result[t], commit_out.result);
        end
        if (commit_out.exception !== wb_exc[t]) begin
            report_mismatch("commit_out.exception", wb_exc[t], commit_out.exception);
        end
        n_commit++;
    endtask

    // ==============================
    // Monitor
    // ==============================

    always @(posedge clk) begin
        int r;
        if (rst_n) begin
            if (dispatch_ack && !ack_q && n_disp < NROWS) begin  // One ack per row
                row_of_tag[exp_tag[n_disp]] = n_disp;
                n_disp++;
            end
            ack_q = dispatch_ack;
            if (dispatch_req && !dispatch_ack && (n_disp - n_commit) == `ROB_DEPTH) begin
                stall_cnt++;  // Request held off by a full ROB
            end
            if ((n_disp - n_commit) > `ROB_DEPTH) begin
                err_cnt++;
                $display("More than %0d instructions in flight at %0t ns", `ROB_DEPTH, $time);
            end
            if (issue_valid) begin
                r = row_of_tag[issue_out.tag];
                if (issue_out.rd !== exp_rd[r]) begin
                    report_mismatch("issue_out.rd", exp_rd[r], issue_out.rd);
                end
                if (issue_out.op !== exp_op[r]) begin
                    report_mismatch("issue_out.op", exp_op[r], issue_out.op);
                end
                if (issue_out.imm !== exp_imm[r]) begin
                    report_mismatch("issue_out.imm", exp_imm[r], issue_out.imm);
                end
                check_producer(r, prod1[r]);
                check_producer(r, prod2[r]);
            end
            if (wb_valid) begin
                done[row_of_tag[wb.tag]] = 1'b1;
                wb_result[wb.tag]        = wb.result;
                wb_exc[wb.tag]           = wb.exception;
            end
            if (commit_valid) begin
                check_commit();
            end
        end
    end

endmodule : tb_window_checker

`default_nettype wire

// ==== window_pkg.sv ====
`default_nettype none

`include "ooo_consts.svh"

package window_pkg;

    import isa_pkg::*;

    // ==============================
    // Tags and operands
    // ==============================

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;  // Reorder buffer index

    typedef struct packed {
        logic     pending;  // Waiting on producer
        rob_tag_t tag;      // Producer tag, only meaningful while pending
    } src_t;

    // ==============================
    // Window interfaces
    // ==============================

    // From the rename stage
    typedef struct packed {
        op_class_e op;
        reg_addr_t rd;
        src_t      src1;
        src_t      src2;
        word_t     imm;
    } dispatch_t;

    // To the execution units
    typedef struct packed {
        rob_tag_t  tag;
        op_class_e op;
        reg_addr_t rd;
        word_t     imm;
    } issue_t;

    // Result returned by tag
    typedef struct packed {
        rob_tag_t tag;
        word_t    result;
        logic     exception;
    } writeback_t;

    // Retired in dispatch order
    typedef struct packed {
        rob_tag_t  tag;
        reg_addr_t rd;
        word_t     result;
        logic      exception;
    } commit_t;

    typedef enum logic [1:0] {
        disp_idle,
        disp_grant,
        disp_release
    } dispatch_state_e;

endpackage : window_pkg

`default_nettype wire
